//--- list.f
common/div_pkg.sv
logic/div_issue.sv
logic/div_input_fifo.sv
div/div_core.sv
div/div_unit.sv
logic/div_subsystem.sv
tb/div_tb.sv

//--- Bender.yml
package:
  name: div_subsystem

sources:
  # shared package first, then leaf blocks, then the top level.
  - common/div_pkg.sv
  - logic/div_issue.sv
  - logic/div_input_fifo.sv
  - div/div_core.sv
  - div/div_unit.sv
  - logic/div_subsystem.sv
  - target: simulation
    files:
      - tb/div_tb.sv

//--- tb/div_tb.sv
`timescale 1ns/1ns

module div_tb;

    localparam int n_entries   = 30;
    localparam int n_passes    = 2;    // second pass runs with the tags wrapped.
    localparam int ready_limit = 400;  // cycles allowed for req_ready.
    localparam int drain_limit = 4000; // cycles allowed to empty the expected queue.

    typedef struct packed {
        div_pkg::div_op_t op;
        logic [31:0]      rs1;
        logic [31:0]      rs2;
    } entry_t;

    logic                  clk;
    logic                  rst;
    logic                  req_valid;
    div_pkg::div_req_t     req;
    logic                  wb_accepted;
    logic                  req_ready;
    logic                  wb_done;
    div_pkg::div_wb_t      wb;

    logic [31:0]           lcg_state;
    div_pkg::div_tag_t     next_tag;
    div_pkg::div_wb_t      exp_q [$]; // results still owed in issue order.
    logic                  saw_full;  // req_ready went low at least once.

    entry_t stim [n_entries] = '{
        '{div_pkg::op_div,  32'd20,        32'd3},
        '{div_pkg::op_div,  -32'd20,       32'd3},
        '{div_pkg::op_divu, -32'd20,       32'd3},
        '{div_pkg::op_rem,  -32'd20,       32'd3},        // signedness differs so no reuse.
        '{div_pkg::op_rem,  32'd20,        -32'd3},
        '{div_pkg::op_remu, 32'd20,        -32'd3},
        '{div_pkg::op_div,  -32'd20,       -32'd3},
        '{div_pkg::op_rem,  -32'd20,       -32'd3},       // reuse.
        '{div_pkg::op_div,  32'd5,         32'd0},
        '{div_pkg::op_divu, 32'd5,         32'd0},
        '{div_pkg::op_rem,  -32'd5,        32'd0},
        '{div_pkg::op_remu, 32'hdeadbeef,  32'd0},
        '{div_pkg::op_div,  32'h8000_0000, 32'hffff_ffff}, // overflow case.
        '{div_pkg::op_rem,  32'h8000_0000, 32'hffff_ffff},
        '{div_pkg::op_div,  32'd100,       -32'd7},
        '{div_pkg::op_rem,  32'd100,       -32'd7},       // reuse.
        '{div_pkg::op_remu, 32'd100,       -32'd7},       // unsigned now so a new pass.
        '{div_pkg::op_divu, 32'd100,       -32'd7},       // reuse of the unsigned pass.
        '{div_pkg::op_div,  32'd1000,      32'd33},
        '{div_pkg::op_rem,  32'd77,        32'd0},        // leaves the held pair alone.
        '{div_pkg::op_rem,  32'd1000,      32'd33},       // reuse across a div by zero.
        '{div_pkg::op_divu, 32'd5,         32'd2},        // small dividends.
        '{div_pkg::op_divu, 32'd0,         32'd9},
        '{div_pkg::op_div,  32'd1,         32'd1},
        '{div_pkg::op_divu, 32'hffff_ffff, 32'd1},        // full range.
        '{div_pkg::op_remu, 32'hffff_ffff, 32'hffff_ffff},
        '{div_pkg::op_remu, 32'hdeadbeef,  32'h1234},
        '{div_pkg::op_div,  32'h7fff_ffff, 32'h8000_0000},
        '{div_pkg::op_rem,  32'h8000_0000, 32'd7},
        '{div_pkg::op_divu, 32'h8000_0000, 32'd3}
    };

    div_subsystem #(
        .fifo_depth (4)
    ) dut (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req         (req),
        .wb_accepted (wb_accepted),
        .req_ready   (req_ready),
        .wb_done     (wb_done),
        .wb          (wb)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period.
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // RV32M rules with truncating division and a remainder that takes the dividend's sign.
    function automatic logic [31:0] ref_divide(input div_pkg::div_op_t op,
                                               input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic [31:0]        res;
        sa = a;
        sb = b;
        if (b == 32'd0) begin
            res = op[1] ? a : 32'hffff_ffff;
        end else if (!op[0] && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            res = op[1] ? 32'd0 : a; // signed overflow.
        end else if (op[0]) begin
            res = op[1] ? a % b : a / b;
        end else begin
            res = op[1] ? sa % sb : sa / sb;
        end
        return res;
    endfunction

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, want);
            abort_run();
        end
    endtask

    // drives one request and returns on the edge where it transfers.
    task automatic issue_request(input entry_t e);
        div_pkg::div_req_t r;
        div_pkg::div_wb_t  x;
        int                waited;
        r.op      = e.op;
        r.rs1     = e.rs1;
        r.rs2     = e.rs2;
        r.tag     = next_tag;
        req_valid <= 1'b1;
        req       <= r;
        waited    = 0;
        @(negedge clk);
        while (!req_ready) begin
            waited++;
            if (waited > ready_limit) begin
                $display("Timed out waiting for req_ready on tag %0d", r.tag);
                abort_run();
            end
            @(negedge clk);
        end
        @(posedge clk); // transfer edge.
        x.rd  = ref_divide(e.op, e.rs1, e.rs2);
        x.tag = r.tag;
        exp_q.push_back(x);
        next_tag = next_tag + 1'b1;
    endtask

    // random back-pressure on the writeback side.
    always @(posedge clk) begin
        if (rst) begin
            wb_accepted <= 1'b0;
        end else begin
            lcg_state   <= lcg_next(lcg_state);
            wb_accepted <= lcg_state[20]; // an upper bit since the low ones have short periods.
        end
    end

    // outputs are flop driven so the falling edge sees them settled.
    always @(negedge clk) begin
        div_pkg::div_wb_t x;
        if (!rst) begin
            if (!req_ready) begin
                saw_full = 1'b1;
            end
            if (wb_done && wb_accepted) begin
                if (exp_q.size() == 0) begin
                    $display("Result with tag %0d arrived when none was expected", wb.tag);
                    abort_run();
                end
                x = exp_q.pop_front();
                check_value("wb.tag", 32'(wb.tag), 32'(x.tag));
                check_value("wb.rd", wb.rd, x.rd);
            end
        end
    end

    initial begin
        int waited;
        rst         = 1'b1;
        req_valid   = 1'b0;
        req         = '0;
        wb_accepted = 1'b0;
        lcg_state   = 32'd26;
        next_tag    = '0;
        saw_full    = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int p = 0; p < n_passes; p++) begin
            for (int i = 0; i < n_entries; i++) begin
                issue_request(stim[i]);
            end
        end
        req_valid <= 1'b0;
        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > drain_limit) begin
                $display("Timed out with %0d results still missing", exp_q.size());
                abort_run();
            end
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("wb_done", 32'(wb_done), 32'd0); // nothing beyond the last result.
        if (!saw_full) begin
            $display("req_ready never dropped, the full FIFO case was not reached");
            abort_run();
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

//--- logic/div_subsystem.sv
`timescale 1ns/1ns

module div_subsystem #(
    parameter int fifo_depth = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    input  div_pkg::div_req_t  req,
    input  logic               wb_accepted,
    output logic               req_ready,
    output logic               wb_done,
    output div_pkg::div_wb_t   wb
);

    logic                  fifo_full;
    logic                  push;
    logic                  pop;
    logic                  head_valid; // buffer not empty.
    div_pkg::div_inputs_t  data_in;    // decoded request.
    div_pkg::div_inputs_t  head;       // oldest pending record.

    div_issue u_issue (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .fifo_full (fifo_full),
        .req_ready (req_ready),
        .push      (push),
        .data_in   (data_in)
    );

    div_input_fifo #(
        .depth (fifo_depth)
    ) u_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (push),
        .pop      (pop),
        .data_in  (data_in),
        .data_out (head),
        .valid    (head_valid),
        .full     (fifo_full)
    );

    div_unit u_unit (
        .clk         (clk),
        .rst         (rst),
        .head        (head),
        .head_valid  (head_valid),
        .wb_accepted (wb_accepted),
        .pop         (pop),
        .wb_done     (wb_done),
        .wb          (wb)
    );

endmodule

//--- div/div_unit.sv
`timescale 1ns/1ns

module div_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  div_pkg::div_inputs_t  head,
    input  logic                  head_valid,
    input  logic                  wb_accepted,
    output logic                  pop,
    output logic                  wb_done,
    output div_pkg::div_wb_t      wb
);

    logic                     start;
    logic                     ack;
    logic                     complete;     // core result ready.
    logic                     in_progress;  // core busy with the head record.
    logic                     abort;        // head needs no divider pass.
    logic                     output_ready; // writeback register free next edge.
    logic                     div_done;     // capture into the writeback register.

    logic                     signed_op;
    logic                     dividend_signed;
    logic                     divisor_signed;
    logic                     quotient_signed;
    logic                     remainder_signed;
    logic                     negate_result;

    logic [div_pkg::xlen-1:0] mag_a;
    logic [div_pkg::xlen-1:0] mag_b;
    logic [div_pkg::xlen-1:0] quotient;
    logic [div_pkg::xlen-1:0] remainder;
    logic [div_pkg::xlen-1:0] result_sel;
    logic [div_pkg::xlen-1:0] result;

    assign abort        = head.div_zero | head.reuse_result;
    assign output_ready = ~wb_done | wb_accepted; // slot frees as the held word leaves.
    assign ack          = complete & output_ready;

    assign start    = head_valid & ~in_progress & ~abort; // one start per record.
    assign div_done = (complete | (head_valid & abort)) & output_ready;
    assign pop      = div_done; // record retires with its capture.

    always_ff @(posedge clk) begin
        if (rst) begin
            in_progress <= 1'b0;
        end else if (start) begin
            in_progress <= 1'b1;
        end else if (ack) begin
            in_progress <= 1'b0;
        end
    end

    // sign handling, bit 0 of op marks the unsigned variants.
    assign signed_op        = ~head.op[0];
    assign dividend_signed  = signed_op & head.rs1[div_pkg::xlen-1];
    assign divisor_signed   = signed_op & head.rs2[div_pkg::xlen-1];
    assign quotient_signed  = signed_op & (head.rs1[div_pkg::xlen-1] ^ head.rs2[div_pkg::xlen-1]);
    assign remainder_signed = signed_op & head.rs1[div_pkg::xlen-1]; // follows the dividend.

    // two's complement magnitudes; the most negative value maps to itself, read unsigned.
    assign mag_a = (dividend_signed ? ~head.rs1 : head.rs1) +
                   div_pkg::xlen'(dividend_signed);
    assign mag_b = (divisor_signed ? ~head.rs2 : head.rs2) +
                   div_pkg::xlen'(divisor_signed);

    assign negate_result = ~head.div_zero &
                           (head.op[1] ? remainder_signed : quotient_signed);

    always_comb begin
        case ({head.div_zero, head.op[1]})
            2'b00:   result_sel = quotient;
            2'b01:   result_sel = remainder;
            2'b10:   result_sel = '1;       // div by zero gives all ones.
            default: result_sel = head.rs1; // rem by zero gives the dividend.
        endcase
        result = (negate_result ? ~result_sel : result_sel) +
                 div_pkg::xlen'(negate_result);
    end

    div_core u_core (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .a        (mag_a),
        .b        (mag_b),
        .ack      (ack),
        .q        (quotient),
        .r        (remainder),
        .complete (complete)
    );

    always_ff @(posedge clk) begin
        if (div_done) begin
            wb.rd  <= result;
            wb.tag <= head.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_done <= 1'b0;
        end else if (div_done) begin
            wb_done <= 1'b1; // back to back capture keeps it high.
        end else if (wb_accepted) begin
            wb_done <= 1'b0;
        end
    end

endmodule

//--- div/div_core.sv
`timescale 1ns/1ns

module div_core (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic [div_pkg::xlen-1:0] a,
    input  logic [div_pkg::xlen-1:0] b,
    input  logic                     ack,
    output logic [div_pkg::xlen-1:0] q,
    output logic [div_pkg::xlen-1:0] r,
    output logic                     complete
);

    localparam int cnt_w = $clog2(div_pkg::xlen + 1);

    logic [div_pkg::xlen-1:0] q_reg;   // dividend bits out the top, quotient bits in below.
    logic [div_pkg::xlen-1:0] r_reg;   // partial remainder.
    logic [div_pkg::xlen-1:0] b_reg;   // divisor.
    logic [cnt_w-1:0]         count;   // bits still to resolve.
    logic                     running;
    logic [2:0]               lz_nibbles;
    logic                     lz_stop;
    logic [cnt_w-1:0]         skip;    // leading bits skipped at start.
    logic [div_pkg::xlen:0]   trial;
    logic [div_pkg::xlen:0]   diff;

    // count leading zero nibbles of a, at most 7 so at least one nibble is processed.
    always_comb begin
        lz_nibbles = '0;
        lz_stop    = 1'b0;
        for (int i = 7; i >= 1; i--) begin
            if (!lz_stop && (a[i*4+3 -: 4] == 4'h0)) begin
                lz_nibbles = lz_nibbles + 1'b1;
            end else begin
                lz_stop = 1'b1;
            end
        end
    end

    assign skip = cnt_w'({lz_nibbles, 2'b00});

    assign trial = {r_reg, q_reg[div_pkg::xlen-1]};   // shift in next dividend bit.
    assign diff  = trial - {1'b0, b_reg};             // msb set means restore.

    always_ff @(posedge clk) begin
        if (rst) begin
            running  <= 1'b0;
            complete <= 1'b0;
        end else if (start) begin
            running  <= 1'b1;
            complete <= 1'b0;
        end else if (running && count == cnt_w'(1)) begin
            running  <= 1'b0;
            complete <= 1'b1; // held until the unit takes it.
        end else if (ack) begin
            complete <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            q_reg <= a << skip;
            r_reg <= '0;
            b_reg <= b;
            count <= cnt_w'(div_pkg::xlen) - skip;
        end else if (running) begin
            q_reg <= {q_reg[div_pkg::xlen-2:0], ~diff[div_pkg::xlen]};
            r_reg <= diff[div_pkg::xlen] ? trial[div_pkg::xlen-1:0] : diff[div_pkg::xlen-1:0];
            count <= count - 1'b1;
        end
    end

    // stable from complete until the next start, the reuse path relies on it.
    assign q = q_reg;
    assign r = r_reg;

endmodule

//--- logic/div_input_fifo.sv
`timescale 1ns/1ns

module div_input_fifo #(
    parameter int depth = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  logic                  pop,
    input  div_pkg::div_inputs_t  data_in,
    output div_pkg::div_inputs_t  data_out,
    output logic                  valid,
    output logic                  full
);

    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    div_pkg::div_inputs_t mem [depth]; // record storage.

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;   // occupancy.
    logic             do_push;
    logic             do_pop;

    assign valid = (count != '0);
    assign full  = (count == cnt_w'(depth));

    assign do_pop  = pop & valid;
    assign do_push = push & (~full | do_pop); // a full buffer takes a push alongside a pop.

    assign data_out = mem[rd_ptr]; // first word fall through.

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                // explicit wrap, depth need not be a power of two.
                if (wr_ptr == ptr_w'(depth - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_pop) begin
                if (rd_ptr == ptr_w'(depth - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // idle or balanced.
            endcase
        end
    end

endmodule

//--- logic/div_issue.sv
`timescale 1ns/1ns

module div_issue (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  div_pkg::div_req_t     req,
    input  logic                  fifo_full,
    output logic                  req_ready,
    output logic                  push,
    output div_pkg::div_inputs_t  data_in
);

    logic [div_pkg::xlen-1:0] last_rs1;      // operands of the last divider request.
    logic [div_pkg::xlen-1:0] last_rs2;
    logic                     last_unsigned; // its signedness.
    logic                     last_seen;     // a divider request was recorded.
    logic                     div_zero;
    logic                     same_operands;
    logic                     reuse;

    assign req_ready = ~fifo_full;          // stall only on a full buffer.
    assign push      = req_valid & req_ready; // transfer cycle.

    assign div_zero = (req.rs2 == '0);

    // the magnitudes fed to the divider depend on rs1, rs2 and signedness only,
    // so a match here means the held quotient and remainder still apply.
    assign same_operands = (req.rs1 == last_rs1) & (req.rs2 == last_rs2) &
                           (req.op[0] == last_unsigned);
    assign reuse = last_seen & same_operands & ~div_zero;

    always_comb begin
        data_in.op           = req.op;
        data_in.rs1          = req.rs1;
        data_in.rs2          = req.rs2;
        data_in.tag          = req.tag;
        data_in.div_zero     = div_zero;
        data_in.reuse_result = reuse; // never set together with div_zero.
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_seen <= 1'b0; // nothing held in the divider yet.
        end else if (push && !div_zero) begin
            last_seen <= 1'b1;
        end
    end

    // operand record; div-by-zero requests bypass the divider and leave it alone.
    always_ff @(posedge clk) begin
        if (push && !div_zero) begin
            last_rs1      <= req.rs1;
            last_rs2      <= req.rs2;
            last_unsigned <= req.op[0];
        end
    end

endmodule

//--- common/div_pkg.sv
package div_pkg;

    // data word width; the sign logic and the RISC-V corner cases assume 32.
    localparam int xlen = 32;

    // RISC-V funct3 low bits.
    // bit 0 marks the unsigned variants, bit 1 marks the remainder variants.
    typedef enum logic [1:0] {
        op_div  = 2'b00, // signed quotient.
        op_divu = 2'b01, // unsigned quotient.
        op_rem  = 2'b10, // signed remainder.
        op_remu = 2'b11  // unsigned remainder.
    } div_op_t;

    // request identifier, returned with the result.
    typedef logic [3:0] div_tag_t;

    // request as presented by the core, 70 bits.
    typedef struct packed {
        div_op_t         op;  // operation.
        logic [xlen-1:0] rs1; // dividend.
        logic [xlen-1:0] rs2; // divisor.
        div_tag_t        tag; // request id.
    } div_req_t;

    // decoded record held in the input FIFO, 72 bits.
    typedef struct packed {
        div_op_t         op;           // operation.
        logic [xlen-1:0] rs1;          // dividend.
        logic [xlen-1:0] rs2;          // divisor.
        div_tag_t        tag;          // request id.
        logic            div_zero;     // divisor is zero.
        logic            reuse_result; // divider already holds this result.
    } div_inputs_t;

    // writeback word, 36 bits.
    typedef struct packed {
        logic [xlen-1:0] rd;  // result.
        div_tag_t        tag; // id of the request it answers.
    } div_wb_t;

endpackage
